//--- rtl/oric_pkg.sv
/*
 * Shared types and constants of the Oric cassette and sound path.
 * Host download beat, store write and sound-level structs,
 * stereo and tape volume modes, file indices and widths.
 */
`default_nettype none

package oric_pkg;

	// File index values sent by the host
	localparam logic [7:0] INDEX_TAPE = 8'd1;
	localparam logic [7:0] INDEX_BIOS = 8'd2;

	// Store address widths
	localparam int TAPE_ADDR_W = 16;
	localparam int BIOS_ADDR_W = 14;

	// Sound widths: one channel, chip mono sum, final sample
	localparam int PSG_W   = 12;
	localparam int MIX_W   = 14;
	localparam int AUDIO_W = 16;

	////////////////////////////////////////////////////////////////////////////

	// One download beat from the host
	typedef struct packed {
		logic                   download;
		logic                   wr;
		logic [7:0]             index;
		logic [TAPE_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} host_load_t;

	// One byte write into a store
	typedef struct packed {
		logic                   we;
		logic [TAPE_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} mem_write_t;

	// Levels from the sound chip
	typedef struct packed {
		logic [PSG_W-1:0] a;
		logic [PSG_W-1:0] b;
		logic [PSG_W-1:0] c;
		logic [MIX_W-1:0] mono;
	} psg_levels_t;

	// Value 3 is treated as ACB
	typedef enum logic [1:0] {
		STEREO_MONO = 2'd0,
		STEREO_ABC  = 2'd1,
		STEREO_ACB  = 2'd2
	} stereo_mode_e;

	// Value 3 is treated as high
	typedef enum logic [1:0] {
		TAPE_MUTE = 2'd0,
		TAPE_LOW  = 2'd1,
		TAPE_HIGH = 2'd2
	} tape_volume_e;

endpackage

`default_nettype wire

//--- rtl/download_decoder.sv
/*
 * Host download decoder.
 * Routes each beat to the tape cache or the BIOS store by file index,
 * records the last tape address and raises the loaded flags.
 */
`default_nettype none

module download_decoder (
	input  wire logic                 clk_sys,
	input  wire logic                 reset,
	input  wire oric_pkg::host_load_t host_load,
	input  wire logic                 tape_rewind,
	output oric_pkg::mem_write_t      tape_wr,
	output oric_pkg::mem_write_t      bios_wr,
	output logic [15:0]               tape_end,
	output logic                      tape_loaded,
	output logic                      bios_loaded,
	output logic                      rewind
);

	logic                             is_tape;
	logic                             is_bios;
	logic                             download_d;
	logic                             tape_we;
	logic                             bios_we;
	logic [oric_pkg::TAPE_ADDR_W-1:0] wr_addr;
	logic [7:0]                       wr_data;

	assign is_tape = (host_load.index == oric_pkg::INDEX_TAPE);
	assign is_bios = (host_load.index == oric_pkg::INDEX_BIOS);

	// Both stores see the same registered beat with their own enables
	assign tape_wr = '{we: tape_we, addr: wr_addr, data: wr_data};
	assign bios_wr = '{we: bios_we, addr: wr_addr, data: wr_data};

	// Tape restarts on request and for as long as a new image comes in
	assign rewind = tape_rewind | (host_load.download & is_tape);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tape_we     <= 1'b0;
			bios_we     <= 1'b0;
			download_d  <= 1'b0;
			tape_loaded <= 1'b0;
			bios_loaded <= 1'b0;
		end else begin
			tape_we    <= host_load.wr & is_tape;
			bios_we    <= host_load.wr & is_bios;
			download_d <= host_load.download;
			// End of a download marks that image as present
			if (download_d && !host_load.download) begin
				if (is_tape)
					tape_loaded <= 1'b1;
				if (is_bios)
					bios_loaded <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		wr_addr <= host_load.addr;
		wr_data <= host_load.data;
		if (host_load.wr && is_tape)
			tape_end <= host_load.addr;
	end

	// Host raises the write strobe only inside a download
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		host_load.wr |-> host_load.download);

endmodule

`default_nettype wire

//--- rtl/image_store.sv
/*
 * Single-port byte memory with registered read.
 * Serves as tape cache and as alternative BIOS store.
 */
`default_nettype none

module image_store #(
	parameter int ADDR_W = 16
) (
	input  wire logic                 clk_sys,
	input  wire oric_pkg::mem_write_t wr,
	input  wire logic [ADDR_W-1:0]    rd_addr,
	output logic [7:0]                rd_data
);

	logic [7:0]        mem [0:(2**ADDR_W)-1];
	logic [ADDR_W-1:0] port_addr;

	// A write takes the single port
	assign port_addr = wr.we ? wr.addr[ADDR_W-1:0] : rd_addr;

	always_ff @(posedge clk_sys) begin
		if (wr.we)
			mem[port_addr] <= wr.data;
		rd_data <= mem[port_addr];
	end

	// Image must fit the store, no aliasing of high addresses
	a_addr_fits: assert property (@(posedge clk_sys)
		wr.we |-> (32'(wr.addr) < (2 ** ADDR_W)));

endmodule

`default_nettype wire

//--- rtl/tape_player.sv
/*
 * Cassette player.
 * Reads the tape cache and shifts each byte out MSB first,
 * one bit per BIT_PERIOD cycles, under motor and rewind control.
 */
`default_nettype none

module tape_player #(
	parameter int BIT_PERIOD = 16
) (
	input  wire logic        clk_sys,
	input  wire logic        reset,
	input  wire logic        motor,
	input  wire logic        tape_loaded,
	input  wire logic        rewind,
	input  wire logic [15:0] tape_end,
	input  wire logic [7:0]  rd_data,
	output logic [15:0]      rd_addr,
	output logic             tape_bit,
	output logic             tape_active
);

	// Prefetch needs at least one cycle of read latency inside a bit
	localparam int PER_W = (BIT_PERIOD > 2) ? $clog2(BIT_PERIOD) : 1;
	localparam logic [PER_W-1:0] PER_LAST = PER_W'(BIT_PERIOD - 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_FETCH,
		S_PLAY,
		S_DONE
	} state_t;

	state_t                           st;
	logic [oric_pkg::TAPE_ADDR_W-1:0] pos;
	logic [2:0]                       bit_cnt;
	logic [PER_W-1:0]                 per_cnt;
	logic [7:0]                       shreg;
	logic                             run;
	logic                             bit_end;
	logic                             byte_end;
	logic                             last_byte;
	logic                             load_byte;
	logic                             shift_bit;

	assign run       = motor & tape_loaded;
	assign bit_end   = (st == S_PLAY) & run & (per_cnt == PER_LAST);
	assign byte_end  = bit_end & (bit_cnt == 3'd7);
	assign last_byte = (pos == tape_end);

	// First byte after start, or the prefetched byte at a byte boundary
	assign load_byte = !rewind & (((st == S_FETCH) & run) | (byte_end & !last_byte));
	assign shift_bit = !rewind & bit_end & (bit_cnt != 3'd7);

	// During the last bit the next byte is already addressed
	assign rd_addr = ((st == S_PLAY) && (bit_cnt == 3'd7)) ? pos + 1'b1 : pos;

	assign tape_active = (st == S_PLAY);
	assign tape_bit    = tape_active & shreg[7];

	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset || rewind) begin
			st      <= S_IDLE;
			pos     <= '0;
			bit_cnt <= '0;
			per_cnt <= '0;
		end else begin
			case (st)
				S_IDLE: begin
					if (run)
						st <= S_FETCH;
				end
				S_FETCH: begin
					bit_cnt <= '0;
					per_cnt <= '0;
					st      <= run ? S_PLAY : S_IDLE;
				end
				S_PLAY: begin
					// Motor off holds every counter
					if (bit_end) begin
						per_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (byte_end) begin
							if (last_byte)
								st <= S_DONE;
							else
								pos <= pos + 1'b1;
						end
					end else if (run) begin
						per_cnt <= per_cnt + 1'b1;
					end
				end
				S_DONE: begin
					// Waits here for a rewind
					st <= S_DONE;
				end
				default: st <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (load_byte)
			shreg <= rd_data;
		else if (shift_bit)
			shreg <= {shreg[6:0], 1'b0};
	end

	// Loaded flag comes from the decoder
	a_idle_unloaded: assert property (@(posedge clk_sys) disable iff (reset)
		!tape_loaded |-> !tape_active);

endmodule

`default_nettype wire

//--- rtl/audio_mixer.sv
/*
 * Audio mixer.
 * Adds the tape bit at the chosen volume to the sound channels
 * and forms registered left and right samples in mono, ABC or ACB.
 */
`default_nettype none

module audio_mixer (
	input  wire logic                   clk_sys,
	input  wire logic                   reset,
	input  wire oric_pkg::psg_levels_t  psg,
	input  wire logic                   tape_bit,
	input  wire oric_pkg::stereo_mode_e stereo_mode,
	input  wire oric_pkg::tape_volume_e tape_volume,
	output logic [oric_pkg::AUDIO_W-1:0] audio_l,
	output logic [oric_pkg::AUDIO_W-1:0] audio_r
);

	logic [oric_pkg::MIX_W-1:0]   tape_lvl;
	logic [oric_pkg::MIX_W-1:0]   mono_sum;
	logic [oric_pkg::PSG_W-1:0]   sum_ab;
	logic [oric_pkg::PSG_W-1:0]   sum_ac;
	logic [oric_pkg::PSG_W-1:0]   sum_bc;
	logic [oric_pkg::AUDIO_W-1:0] next_l;
	logic [oric_pkg::AUDIO_W-1:0] next_r;

	// Tape level: 512 at low, 1024 at high
	always_comb begin
		case (tape_volume)
			oric_pkg::TAPE_MUTE: tape_lvl = '0;
			oric_pkg::TAPE_LOW:  tape_lvl = oric_pkg::MIX_W'({tape_bit, 9'd0});
			default:             tape_lvl = oric_pkg::MIX_W'({tape_bit, 10'd0});
		endcase
	end

	// Sums wrap at their own width
	assign mono_sum = psg.mono + tape_lvl;
	assign sum_ab   = psg.a + psg.b + tape_lvl[oric_pkg::PSG_W-1:0];
	assign sum_ac   = psg.a + psg.c + tape_lvl[oric_pkg::PSG_W-1:0];
	assign sum_bc   = psg.b + psg.c + tape_lvl[oric_pkg::PSG_W-1:0];

	always_comb begin
		case (stereo_mode)
			oric_pkg::STEREO_MONO: begin
				next_l = oric_pkg::AUDIO_W'({mono_sum, 1'b0});
				next_r = oric_pkg::AUDIO_W'({mono_sum, 1'b0});
			end
			oric_pkg::STEREO_ABC: begin
				next_l = oric_pkg::AUDIO_W'({sum_ab, 1'b0});
				next_r = oric_pkg::AUDIO_W'({sum_bc, 1'b0});
			end
			default: begin
				next_l = oric_pkg::AUDIO_W'({sum_ac, 1'b0});
				next_r = oric_pkg::AUDIO_W'({sum_bc, 1'b0});
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= next_l;
			audio_r <= next_r;
		end
	end

endmodule

`default_nettype wire

//--- rtl/oric_tape_audio.sv
/*
 * Oric cassette and sound path, top level.
 * Download decoder, tape cache, BIOS store, tape player and audio mixer.
 */
`default_nettype none

module oric_tape_audio #(
	parameter int BIT_PERIOD = 16
) (
	input  wire logic                            clk_sys,
	input  wire logic                            reset,

	// Host file download
	input  wire oric_pkg::host_load_t            host_load,

	// Cassette control from the machine
	input  wire logic                            tape_motor,
	input  wire logic                            tape_rewind,

	// BIOS read port
	input  wire logic [oric_pkg::BIOS_ADDR_W-1:0] bios_addr,
	output logic [7:0]                           bios_data,

	// Sound settings and levels
	input  wire oric_pkg::psg_levels_t           psg,
	input  wire oric_pkg::stereo_mode_e          stereo_mode,
	input  wire oric_pkg::tape_volume_e          tape_volume,

	output logic                                 tape_loaded,
	output logic                                 bios_loaded,
	output logic                                 tape_bit,
	output logic                                 tape_active,
	output logic [oric_pkg::AUDIO_W-1:0]         audio_l,
	output logic [oric_pkg::AUDIO_W-1:0]         audio_r
);

	oric_pkg::mem_write_t             tape_wr;
	oric_pkg::mem_write_t             bios_wr;
	logic [15:0]                      tape_end;
	logic                             rewind;
	logic [oric_pkg::TAPE_ADDR_W-1:0] tape_rd_addr;
	logic [7:0]                       tape_rd_data;
	logic                             bios_download;
	logic [oric_pkg::BIOS_ADDR_W-1:0] bios_rd_addr;

	////////////////////////////////////////////////////////////////////////////
	// Download side

	download_decoder u_decoder (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.host_load   (host_load),
		.tape_rewind (tape_rewind),
		.tape_wr     (tape_wr),
		.bios_wr     (bios_wr),
		.tape_end    (tape_end),
		.tape_loaded (tape_loaded),
		.bios_loaded (bios_loaded),
		.rewind      (rewind)
	);

	image_store #(
		.ADDR_W (oric_pkg::TAPE_ADDR_W)
	) u_tape_cache (
		.clk_sys (clk_sys),
		.wr      (tape_wr),
		.rd_addr (tape_rd_addr),
		.rd_data (tape_rd_data)
	);

	// Download address owns the BIOS port while the image comes in
	assign bios_download = host_load.download & (host_load.index == oric_pkg::INDEX_BIOS);
	assign bios_rd_addr  = bios_download ? bios_wr.addr[oric_pkg::BIOS_ADDR_W-1:0] : bios_addr;

	image_store #(
		.ADDR_W (oric_pkg::BIOS_ADDR_W)
	) u_bios_store (
		.clk_sys (clk_sys),
		.wr      (bios_wr),
		.rd_addr (bios_rd_addr),
		.rd_data (bios_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// Playback and sound

	tape_player #(
		.BIT_PERIOD (BIT_PERIOD)
	) u_player (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.motor       (tape_motor),
		.tape_loaded (tape_loaded),
		.rewind      (rewind),
		.tape_end    (tape_end),
		.rd_data     (tape_rd_data),
		.rd_addr     (tape_rd_addr),
		.tape_bit    (tape_bit),
		.tape_active (tape_active)
	);

	audio_mixer u_mixer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.psg         (psg),
		.tape_bit    (tape_bit),
		.stereo_mode (stereo_mode),
		.tape_volume (tape_volume),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

endmodule

`default_nettype wire

//--- verification/tape_audio_checker.sv
/*
 * Checker for the Oric cassette and sound path.
 * Holds the tape and BIOS byte model and the mixing rule,
 * and compares the DUT ports against them.
 */
`default_nettype none

module tape_audio_checker #(
	parameter int BIT_PERIOD = 4
) (
	input wire logic                   clk_sys,
	input wire logic                   tape_motor,
	input wire logic                   tape_loaded,
	input wire logic                   bios_loaded,
	input wire logic                   tape_bit,
	input wire logic                   tape_active,
	input wire logic [7:0]             bios_data,
	input wire oric_pkg::psg_levels_t  psg,
	input wire oric_pkg::stereo_mode_e stereo_mode,
	input wire oric_pkg::tape_volume_e tape_volume,
	input wire logic [15:0]            audio_l,
	input wire logic [15:0]            audio_r
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0]            tape_model [0:63];
	logic [7:0]            bios_model [0:63];
	int                    errors;
	oric_pkg::psg_levels_t cap_psg;
	logic [1:0]            cap_mode;
	logic [1:0]            cap_vol;
	logic                  cap_bit;

	initial errors = 0;

	// Mixer inputs as the DUT registers them on this edge
	always @(posedge clk_sys) begin
		cap_psg  <= psg;
		cap_mode <= stereo_mode;
		cap_vol  <= tape_volume;
		cap_bit  <= tape_bit;
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic report_problem(input string text);
		errors++;
		$display("Failure: %s", text);
	endtask

	task automatic remember(input bit tape, input int addr, input logic [7:0] data);
		if (tape)
			tape_model[addr] = data;
		else
			bios_model[addr] = data;
	endtask

	// Mono wraps at 14 bits, stereo pairs at 12 bits, then doubled
	function automatic logic [15:0] expected_side(input bit right);
		int lvl;
		int sum;
		lvl = (cap_vol == 2'd0) ? 0 : (cap_vol == 2'd1) ? 512 * int'(cap_bit) : 1024 * int'(cap_bit);
		if (cap_mode == 2'd0)
			return 16'(((int'(cap_psg.mono) + lvl) % 16384) * 2);
		if (right)
			sum = int'(cap_psg.b) + int'(cap_psg.c);
		else if (cap_mode == 2'd1)
			sum = int'(cap_psg.a) + int'(cap_psg.b);
		else
			sum = int'(cap_psg.a) + int'(cap_psg.c);
		return 16'(((sum + lvl) % 4096) * 2);
	endfunction

	////////////////////////////////////////////////////////////////////////////

	task automatic check_idle();
		@(negedge clk_sys);
		check_value("tape_loaded", tape_loaded, 0);
		check_value("bios_loaded", bios_loaded, 0);
		check_value("tape_active", tape_active, 0);
		check_value("tape_bit", tape_bit, 0);
		check_value("audio_l", audio_l, 0);
		check_value("audio_r", audio_r, 0);
	endtask

	task automatic wait_loaded(input bit tape);
		int waited;
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (!(tape ? tape_loaded : bios_loaded) && waited < 50);
		if (!(tape ? tape_loaded : bios_loaded))
			report_problem(tape ? "tape_loaded never rose" : "bios_loaded never rose");
	endtask

	// Address was driven on the previous edge
	task automatic check_bios(input int addr);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("bios_data", bios_data, bios_model[addr]);
		check_value("tape_loaded", tape_loaded, 0);
	endtask

	// Samples mid-bit, counting only cycles in which the motor runs
	task automatic check_stream(input int len, input bit check_latency);
		int         waited;
		int         c;
		int         n;
		logic [7:0] exp;
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (!tape_active && waited < 100);
		if (!tape_active) begin
			report_problem("tape_active never rose");
			return;
		end
		if (check_latency)
			check_value("tape_active latency", waited - 1, 2);
		c = 0;
		n = 0;
		waited = 0;
		while (n < 8 * len && waited < 4000) begin
			if (tape_motor) begin
				if (c % BIT_PERIOD == BIT_PERIOD / 2 - 1) begin
					exp = tape_model[n / 8];
					check_value("tape_bit", tape_bit, exp[7 - (n % 8)]);
					check_value("tape_active", tape_active, 1);
					n++;
				end
				c++;
			end
			@(negedge clk_sys);
			waited++;
		end
		if (n < 8 * len)
			report_problem("tape stream stalled before the last bit");
		waited = 0;
		while (tape_active && waited < 100) begin
			@(negedge clk_sys);
			waited++;
		end
		if (tape_active)
			report_problem("tape_active did not fall after the last byte");
		check_value("tape_bit", tape_bit, 0);
	endtask

	task automatic check_mix(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk_sys);
			check_value("audio_l", audio_l, expected_side(1'b0));
			check_value("audio_r", audio_r, expected_side(1'b1));
		end
	endtask

endmodule

`default_nettype wire

//--- verification/tb_oric_tape_audio.sv
/*
 * Testbench for the Oric cassette and sound path.
 * Clock, reset, LFSR stimulus and the test sequence.
 */
`default_nettype none

module tb_oric_tape_audio;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int BIT_PERIOD = 4;

	logic                   clk_sys;
	logic                   reset;
	oric_pkg::host_load_t   host_load;
	logic                   tape_motor;
	logic                   tape_rewind;
	logic [13:0]            bios_addr;
	logic [7:0]             bios_data;
	oric_pkg::psg_levels_t  psg;
	oric_pkg::stereo_mode_e stereo_mode;
	oric_pkg::tape_volume_e tape_volume;
	logic                   tape_loaded;
	logic                   bios_loaded;
	logic                   tape_bit;
	logic                   tape_active;
	logic [15:0]            audio_l;
	logic [15:0]            audio_r;
	logic [15:0]            lfsr;
	int                     tests_run;
	int                     tests_failed;
	int                     err_before;
	int                     tape_len;
	int                     bios_len;
	bit                     stream_done;

	oric_tape_audio #(.BIT_PERIOD(BIT_PERIOD)) u_dut (.*);

	tape_audio_checker #(.BIT_PERIOD(BIT_PERIOD)) u_checker (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic finish_test(input string name);
		tests_run++;
		if (u_checker.errors != err_before) begin
			tests_failed++;
			$display("%-16s failed", name);
		end else begin
			$display("%-16s ok", name);
		end
		err_before = u_checker.errors;
	endtask

	task automatic load_image(input logic [7:0] index, input int len);
		logic [7:0] b;
		for (int i = 0; i < len; i++) begin
			b = 8'(take_bits(8));
			@(posedge clk_sys);
			host_load <= '{download: 1'b1, wr: 1'b1, index: index, addr: 16'(i), data: b};
			u_checker.remember(index == oric_pkg::INDEX_TAPE, i, b);
		end
		@(posedge clk_sys);
		host_load.wr       <= 1'b0;
		host_load.download <= 1'b0;
	endtask

	task automatic pulse_rewind();
		@(posedge clk_sys);
		tape_rewind <= 1'b1;
		@(posedge clk_sys);
		tape_rewind <= 1'b0;
	endtask

	// Motor mostly on, with short random stops
	task automatic toggle_motor();
		int guard;
		guard = 0;
		while (!stream_done && guard < 4000) begin
			@(posedge clk_sys);
			tape_motor <= (take_bits(2) != 0);
			guard++;
		end
		tape_motor <= 1'b1;
	endtask

	task automatic drive_mix();
		for (int m = 0; m < 4; m++) begin
			for (int v = 0; v < 4; v++) begin
				repeat (8) begin
					@(posedge clk_sys);
					psg <= '{a: 12'(take_bits(12)), b: 12'(take_bits(12)),
						c: 12'(take_bits(12)), mono: 14'(take_bits(14))};
					stereo_mode <= oric_pkg::stereo_mode_e'(m);
					tape_volume <= oric_pkg::tape_volume_e'(v);
				end
			end
		end
	endtask

	initial begin
		lfsr         = 16'd62;
		tests_run    = 0;
		tests_failed = 0;
		err_before   = 0;
		stream_done  = 1'b0;
		reset        = 1'b1;
		host_load    = '0;
		tape_motor   = 1'b0;
		tape_rewind  = 1'b0;
		bios_addr    = '0;
		psg          = '0;
		stereo_mode  = oric_pkg::STEREO_MONO;
		tape_volume  = oric_pkg::TAPE_MUTE;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		u_checker.check_idle();
		finish_test("reset");

		bios_len = 8 + int'(take_bits(5));
		load_image(oric_pkg::INDEX_BIOS, bios_len);
		u_checker.wait_loaded(1'b0);
		for (int i = 0; i < bios_len; i++) begin
			@(posedge clk_sys);
			bios_addr <= 14'(i);
			u_checker.check_bios(i);
		end
		finish_test("bios download");

		tape_len = 4 + int'(take_bits(4));
		load_image(oric_pkg::INDEX_TAPE, tape_len);
		u_checker.wait_loaded(1'b1);
		@(posedge clk_sys);
		tape_motor <= 1'b1;
		u_checker.check_stream(tape_len, 1'b1);
		finish_test("tape playback");

		pulse_rewind();
		fork
			begin
				u_checker.check_stream(tape_len, 1'b0);
				stream_done = 1'b1;
			end
			toggle_motor();
		join
		repeat (20 + int'(take_bits(5))) @(posedge clk_sys);
		pulse_rewind();
		u_checker.check_stream(tape_len, 1'b0);
		finish_test("pause and rewind");

		pulse_rewind();
		fork
			u_checker.check_mix(128);
			drive_mix();
		join
		finish_test("mixing");

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, u_checker.errors);
		if (tests_failed == 0 && u_checker.errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- oric_tape_audio.f
rtl/oric_pkg.sv
rtl/download_decoder.sv
rtl/image_store.sv
rtl/tape_player.sv
rtl/audio_mixer.sv
rtl/oric_tape_audio.sv
verification/tape_audio_checker.sv
verification/tb_oric_tape_audio.sv

//--- Makefile
SIM := obj_dir/Vtb_oric_tape_audio

.PHONY: all run clean

all: run

$(SIM): oric_tape_audio.f rtl/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_oric_tape_audio -f oric_tape_audio.f

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir
